// ==== build.f ====
verilog/RiscVPkg.sv
verilog/RiscVAlu.sv
verilog/RegFile.sv
verilog/RiscV1StageControl.sv
verilog/RiscV1StageDatapath.sv
verilog/MemoryArbiter.sv
verilog/UnifiedMemory.sv
verilog/RiscVSystem.sv
testbench/RiscVSystem_checker.sv
testbench/RiscVSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator, result is taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module RiscVSystemTb -f build.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1

// ==== testbench/RiscVSystemTb.sv ====
`timescale 1ns/1ns

module RiscVSystemTb import RiscVPkg::*; ();
    logic clk;
    logic reset;
    logic [31:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [4:0] readRegisterDebug;
    logic [31:0] readDataDebug;

    int errorCount;
    int checkCount;
    logic [31:0] lfsrState;
    logic [31:0] programWords[$];

    RiscVSystem DUT (
        .clk(clk),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .readRegisterDebug(readRegisterDebug),
        .readDataDebug(readDataDebug)
    );

    always #5 clk = ~clk;

    // instruction encoders, one per RV32I format
    function automatic logic [31:0] encI(opcode_t op, int rd, int f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] encS(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encB(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encU(opcode_t op, int rd, int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encJ(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic randomBits(input int count, output logic [31:0] value);
        value = 32'b0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("checks: %0d, errors: %0d, timeouts: 1", checkCount, errorCount);
        $display("Test failed");
        $finish;
    endtask

    // one APB3 transfer, setup then access until pready
    task automatic busTransfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int waits;
        @(posedge clk);
        #1;
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > 64) begin
                abortRun("APB transfer saw no pready within 64 wait states");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic err;
        busTransfer(1'b1, addr, data, unused, err);
        checkValue($sformatf("pslverr of write to %h", addr), {31'b0, err}, 32'd0);
    endtask

    task automatic apbRead(input logic [31:0] addr, output logic [31:0] data,
                           output logic err);
        busTransfer(1'b0, addr, 32'b0, data, err);
    endtask

    task automatic readRegister(input int index, output logic [31:0] value);
        @(posedge clk);
        #1;
        readRegisterDebug = index[4:0];
        @(negedge clk);
        value = readDataDebug;
    endtask

    task automatic checkRegister(input int index, input logic [31:0] expected);
        logic [31:0] value;
        readRegister(index, value);
        checkValue($sformatf("x%0d", index), value, expected);
    endtask

    task automatic emit(input logic [31:0] word);
        programWords.push_back(word);
    endtask

    task automatic waitHalted();
        logic [31:0] status;
        logic err;
        int polls;
        polls = 0;
        status = 32'b0;
        while (!status[1]) begin
            polls++;
            if (polls > 2000) begin
                abortRun("core did not halt within 2000 status polls");
            end
            apbRead(CTRL_ADDR, status, err);
        end
    endtask

    // program goes to address 0, then run is set
    task automatic runProgram();
        for (int i = 0; i < programWords.size(); i++) begin
            apbWrite(i * 4, programWords[i]);
        end
        programWords.delete();
        apbWrite(CTRL_ADDR, 32'd1);
        waitHalted();
    endtask

    task automatic memoryAccessTest();
        logic [31:0] written[16];
        logic [31:0] data;
        logic err;
        for (int i = 0; i < 16; i++) begin
            randomBits(32, written[i]);
            apbWrite(32'h400 + i * 8, written[i]);
        end
        for (int i = 0; i < 16; i++) begin
            apbRead(32'h400 + i * 8, data, err);
            checkValue($sformatf("readback of %h", 32'h400 + i * 8), data, written[i]);
        end
        // beyond 4 KB and not the control word
        apbRead(32'h0000_1000, data, err);
        checkValue("pslverr beyond 4 KB", {31'b0, err}, 32'd1);
        checkValue("read data beyond 4 KB", data, 32'd0);
    endtask

    task automatic aluImmediateTest();
        logic [31:0] expected[15];
        emit(encU(OPC_LUI, 1, 'h12345));
        emit(encU(OPC_AUIPC, 2, 1));
        emit(encI(OPC_OP_IMM, 3, 0, 0, -5));
        emit(encI(OPC_OP_IMM, 4, 0, 1, 'h678));
        emit(encI(OPC_OP_IMM, 5, 1, 4, 4));
        emit(encI(OPC_OP_IMM, 6, 5, 3, 28));
        emit(encI(OPC_OP_IMM, 7, 5, 3, 'h401));
        emit(encR(0, 6, 3, 2, 8));
        emit(encR(0, 6, 3, 3, 9));
        emit(encR('h20, 1, 4, 0, 10));
        emit(encR(0, 3, 4, 4, 11));
        emit(encR(0, 6, 1, 6, 12));
        emit(encR(0, 3, 4, 7, 13));
        emit(encR(0, 6, 6, 1, 14));
        emit(encI(OPC_OP_IMM, 0, 0, 0, 7));
        emit(encI(OPC_SYSTEM, 0, 0, 0, 0));
        runProgram();
        expected[0] = 32'd0;
        expected[1] = 32'h12345 << 12;
        // auipc sits at pc 4
        expected[2] = 32'd4 + (32'd1 << 12);
        expected[3] = 32'd0 - 32'd5;
        expected[4] = expected[1] + 32'h678;
        expected[5] = expected[4] << 4;
        expected[6] = expected[3] >> 28;
        expected[7] = {expected[3][31], expected[3][31:1]};
        expected[8] = {31'b0, $signed(expected[3]) < $signed(expected[6])};
        expected[9] = {31'b0, expected[3] < expected[6]};
        expected[10] = expected[4] - expected[1];
        expected[11] = expected[4] ^ expected[3];
        expected[12] = expected[1] | expected[6];
        expected[13] = expected[4] & expected[3];
        expected[14] = expected[6] << expected[6][4:0];
        for (int r = 0; r < 15; r++) begin
            checkRegister(r, expected[r]);
        end
    endtask

    task automatic loadStoreBranchTest();
        logic [31:0] word;
        logic [31:0] sum;
        logic [31:0] data;
        logic err;
        sum = 32'd0;
        for (int i = 0; i < 5; i++) begin
            randomBits(32, word);
            apbWrite(32'h300 + i * 4, word);
            sum = sum + word;
        end
        emit(encI(OPC_OP_IMM, 1, 0, 0, 'h300));
        emit(encI(OPC_OP_IMM, 2, 0, 0, 0));
        emit(encI(OPC_OP_IMM, 3, 0, 0, 5));
        emit(encI(OPC_OP_IMM, 4, 0, 0, 0));
        // loop body at 16
        emit(encI(OPC_LOAD, 5, 2, 1, 0));
        emit(encR(0, 5, 2, 0, 2));
        emit(encI(OPC_OP_IMM, 1, 0, 1, 4));
        emit(encI(OPC_OP_IMM, 4, 0, 4, 1));
        emit(encB(1, 4, 3, -16));
        // taken blt skips the corrupting addi
        emit(encB(4, 0, 3, 8));
        emit(encI(OPC_OP_IMM, 2, 0, 2, 1));
        emit(encS(2, 1, 'h20));
        emit(encI(OPC_SYSTEM, 0, 0, 0, 0));
        runProgram();
        apbRead(32'h334, data, err);
        checkValue("stored sum", data, sum);
    endtask

    task automatic jumpTest();
        emit(encI(OPC_OP_IMM, 5, 0, 0, 0));
        emit(encJ(1, 12));
        emit(encI(OPC_OP_IMM, 5, 0, 0, 1));
        emit(encI(OPC_OP_IMM, 5, 0, 0, 2));
        emit(encI(OPC_OP_IMM, 6, 0, 0, 36));
        // odd target, low bit is dropped
        emit(encI(OPC_JALR, 7, 0, 6, 5));
        emit(encI(OPC_OP_IMM, 5, 0, 0, 3));
        emit(encI(OPC_OP_IMM, 5, 0, 0, 4));
        emit(encI(OPC_OP_IMM, 5, 0, 0, 5));
        emit(encI(OPC_OP_IMM, 5, 0, 0, 6));
        emit(encI(OPC_OP_IMM, 8, 0, 0, 'h55));
        emit(encI(OPC_SYSTEM, 0, 0, 0, 0));
        runProgram();
        checkRegister(1, 32'd8);
        checkRegister(7, 32'd24);
        checkRegister(5, 32'd0);
        checkRegister(8, 32'h55);
    endtask

    task automatic backPressureTest();
        logic [31:0] bits;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] data;
        logic err;
        emit(encI(OPC_OP_IMM, 1, 0, 0, 'h380));
        emit(encI(OPC_OP_IMM, 2, 0, 0, 0));
        emit(encI(OPC_OP_IMM, 3, 0, 0, 200));
        emit(encS(2, 1, 0));
        emit(encI(OPC_LOAD, 4, 2, 1, 0));
        emit(encI(OPC_OP_IMM, 2, 0, 4, 1));
        emit(encB(1, 2, 3, -12));
        emit(encI(OPC_SYSTEM, 0, 0, 0, 0));
        for (int i = 0; i < programWords.size(); i++) begin
            apbWrite(i * 4, programWords[i]);
        end
        programWords.delete();
        apbWrite(CTRL_ADDR, 32'd1);
        // host traffic in 0x800..0xbfc while the loop runs
        for (int i = 0; i < 16; i++) begin
            randomBits(8, bits);
            addr = 32'h800 + {22'b0, bits[7:0], 2'b00};
            randomBits(32, word);
            apbWrite(addr, word);
            apbRead(addr, data, err);
            checkValue($sformatf("pslverr of read from %h", addr), {31'b0, err}, 32'd0);
            checkValue($sformatf("readback of %h", addr), data, word);
        end
        waitHalted();
        checkRegister(2, 32'd200);
        apbRead(32'h380, data, err);
        checkValue("last stored count", data, 32'd199);
    endtask

    task automatic haltRestartTest();
        logic [31:0] status;
        logic err;
        // known start value for the counter register
        emit(encI(OPC_OP_IMM, 10, 0, 0, 'h30));
        emit(encI(OPC_SYSTEM, 0, 0, 0, 0));
        runProgram();
        emit(encI(OPC_OP_IMM, 10, 0, 10, 1));
        emit(encI(OPC_SYSTEM, 0, 0, 0, 0));
        runProgram();
        apbRead(CTRL_ADDR, status, err);
        checkValue("status after ecall", status, 32'd2);
        checkRegister(10, 32'h31);
        // restart from RESET_PC repeats the increment
        apbWrite(CTRL_ADDR, 32'd1);
        waitHalted();
        apbRead(CTRL_ADDR, status, err);
        checkValue("status after restart", status, 32'd2);
        checkRegister(10, 32'h32);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        paddr = 32'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'b0;
        readRegisterDebug = 5'd0;
        errorCount = 0;
        checkCount = 0;
        lfsrState = 32'h2c76;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        memoryAccessTest();
        aluImmediateTest();
        loadStoreBranchTest();
        jumpTest();
        backPressureTest();
        haltRestartTest();

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/RiscVSystem_checker.sv ====
`timescale 1ns/1ns

module RiscVSystem_checker (
    input logic        clk,
    input logic        reset,
    input logic [31:0] paddr,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [31:0] pwdata,
    input logic        pready,
    input logic        coreRead,
    input logic        coreWrite,
    input logic        run,
    input logic        halted
);
    // the core always wins the data port
    readyWhileCoreBusy: assert property (@(posedge clk) disable iff (reset)
        (coreRead || coreWrite) |-> !pready)
        else $error("pready was high while the core used the data port");

    // host holds the transfer during wait states
    apbStableWhileWaiting: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pready) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else $error("APB signals changed while pready was low");

    runAndHalted: assert property (@(posedge clk) disable iff (reset) !(run && halted))
        else $error("run and halted were high together");

endmodule

bind MemoryArbiter RiscVSystem_checker arbiterChecker (
    .clk(clk),
    .reset(reset),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .pwdata(pwdata),
    .pready(pready),
    .coreRead(coreRead),
    .coreWrite(coreWrite),
    .run(run),
    .halted(halted)
);

// ==== verilog/MemoryArbiter.sv ====
`timescale 1ns/1ns

module MemoryArbiter import RiscVPkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic [31:0]              coreAddress,
    input  logic [31:0]              coreWriteData,
    input  logic                     coreRead,
    input  logic                     coreWrite,
    output logic [31:0]              coreReadData,
    input  logic                     halt,
    output logic                     run,
    output logic [MEM_ADDR_BITS-1:0] dataAddress,
    output logic                     dataWrite,
    output logic [31:0]              dataWriteData,
    input  logic [31:0]              dataReadData
);
    logic halted;
    logic coreBusy;
    logic apbAccess;
    logic apbDone;
    logic memHit;
    logic ctrlHit;

    assign coreBusy = coreRead || coreWrite;
    assign apbAccess = psel && penable;
    // core owns the port, host waits
    assign apbDone = apbAccess && !coreBusy;

    // first 4 KB is memory, one control word above it
    assign memHit = (paddr[31:MEM_ADDR_BITS+2] == '0);
    assign ctrlHit = (paddr == CTRL_ADDR);

    assign pready = apbDone;
    assign pslverr = apbDone && !memHit && !ctrlHit;

    always_comb begin
        if (memHit) begin
            prdata = dataReadData;
        end else if (ctrlHit) begin
            prdata = {30'b0, halted, run};
        end else begin
            prdata = 32'b0;
        end
    end

    assign dataAddress = coreBusy ? coreAddress[MEM_ADDR_BITS+1:2] : paddr[MEM_ADDR_BITS+1:2];
    assign dataWriteData = coreBusy ? coreWriteData : pwdata;
    assign dataWrite = coreBusy ? coreWrite : (apbDone && pwrite && memHit);
    assign coreReadData = dataReadData;

    // run/status register, ecall wins over a host write in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
            halted <= 1'b0;
        end else if (halt) begin
            run <= 1'b0;
            halted <= 1'b1;
        end else if (apbDone && pwrite && ctrlHit) begin
            run <= pwdata[0];
            if (pwdata[0]) begin
                halted <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/RegFile.sv ====
`timescale 1ns/1ns

module RegFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  readRegister1,
    input  logic [4:0]  readRegister2,
    input  logic [4:0]  writeRegister,
    input  logic [31:0] writeData,
    input  logic        writeEnable,
    output logic [31:0] readData1,
    output logic [31:0] readData2,
    input  logic [4:0]  readRegisterDebug,
    output logic [31:0] readDataDebug
);
    logic [31:0] registers [32];

    // x0 reads as zero whatever the array holds
    assign readData1 = (readRegister1 == 5'd0) ? 32'b0 : registers[readRegister1];
    assign readData2 = (readRegister2 == 5'd0) ? 32'b0 : registers[readRegister2];
    assign readDataDebug = (readRegisterDebug == 5'd0) ? 32'b0 : registers[readRegisterDebug];

    // no writes land while in reset
    always_ff @(posedge clk) begin
        if (!reset && writeEnable && writeRegister != 5'd0) begin
            registers[writeRegister] <= writeData;
        end
    end

endmodule

// ==== verilog/RiscV1StageControl.sv ====
`timescale 1ns/1ns

module RiscV1StageControl import RiscVPkg::*; (
    input  logic [31:0] instruction,
    input  logic        branchEqual,
    input  logic        branchLess,
    output pcSel_t      pcSelect,
    output op1Sel_t     op1Select,
    output op2Sel_t     op2Select,
    output aluOp_t      aluFunction,
    output wbSel_t      writebackSelect,
    output logic        regFileWriteEnable,
    output logic        memoryReadEnable,
    output logic        memoryWriteEnable,
    output logic        isEcall
);
    opcode_t opcode;
    logic [2:0] funct3;
    logic funct7Bit;
    logic branchTaken;

    assign opcode = opcode_t'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7Bit = instruction[30];

    // funct7 bit only selects SUB for register-register ops
    function automatic aluOp_t decodeAluOp(input logic [2:0] f3, input logic f7,
                                           input logic isRegister);
        aluOp_t op;
        case (f3)
            3'b000: op = (isRegister && f7) ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = f7 ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // beq, bne, blt, bge
    always_comb begin
        case (funct3)
            3'b000: branchTaken = branchEqual;
            3'b001: branchTaken = !branchEqual;
            3'b100: branchTaken = branchLess;
            3'b101: branchTaken = !branchLess;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        // defaults decode to a nop
        pcSelect = PC_PLUS4;
        op1Select = OP1_ZERO;
        op2Select = OP2_RS2;
        aluFunction = ALU_ADD;
        writebackSelect = WB_ALU;
        regFileWriteEnable = 1'b0;
        memoryReadEnable = 1'b0;
        memoryWriteEnable = 1'b0;
        isEcall = 1'b0;

        case (opcode)
            OPC_OP: begin
                op1Select = OP1_RS1;
                aluFunction = decodeAluOp(funct3, funct7Bit, 1'b1);
                regFileWriteEnable = 1'b1;
            end
            OPC_OP_IMM: begin
                op1Select = OP1_RS1;
                op2Select = OP2_IMM_I;
                aluFunction = decodeAluOp(funct3, funct7Bit, 1'b0);
                regFileWriteEnable = 1'b1;
            end
            OPC_LOAD: begin
                // word loads only
                if (funct3 == 3'b010) begin
                    op1Select = OP1_RS1;
                    op2Select = OP2_IMM_I;
                    writebackSelect = WB_MEM;
                    regFileWriteEnable = 1'b1;
                    memoryReadEnable = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    op1Select = OP1_RS1;
                    op2Select = OP2_IMM_S;
                    memoryWriteEnable = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (branchTaken) begin
                    pcSelect = PC_BRANCH;
                end
            end
            OPC_JAL: begin
                pcSelect = PC_JUMP;
                writebackSelect = WB_PC4;
                regFileWriteEnable = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    pcSelect = PC_JALR;
                    writebackSelect = WB_PC4;
                    regFileWriteEnable = 1'b1;
                end
            end
            OPC_LUI: begin
                op2Select = OP2_IMM_U;
                aluFunction = ALU_COPY_B;
                regFileWriteEnable = 1'b1;
            end
            OPC_AUIPC: begin
                op1Select = OP1_PC;
                op2Select = OP2_IMM_U;
                regFileWriteEnable = 1'b1;
            end
            OPC_SYSTEM: begin
                isEcall = (instruction == ECALL_WORD);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/RiscV1StageDatapath.sv ====
`timescale 1ns/1ns

module RiscV1StageDatapath import RiscVPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    output logic        halt,
    output logic [31:0] pc,
    input  logic [31:0] instruction,
    output logic [31:0] aluOut,
    output logic [31:0] rs2,
    output logic        memoryReadEnable,
    output logic        memoryWriteEnable,
    input  logic [31:0] memoryOut,
    input  logic [4:0]  readRegisterDebug,
    output logic [31:0] readDataDebug
);
    pcSel_t pcSelect;
    op1Sel_t op1Select;
    op2Sel_t op2Select;
    aluOp_t aluFunction;
    wbSel_t writebackSelect;
    logic decodedRegWrite;
    logic decodedRead;
    logic decodedWrite;
    logic isEcall;
    logic runDelayed;
    logic runStart;
    logic active;
    logic branchEqual;
    logic branchLess;
    logic [31:0] rs1;
    logic [31:0] pcPlus4;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] immU;
    logic [31:0] nextPc;
    logic [31:0] leftOperand;
    logic [31:0] rightOperand;
    logic [31:0] writebackData;

    // first cycle of run only reloads the pc, execution follows
    assign runStart = run && !runDelayed;
    assign active = run && runDelayed;

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};
    assign immU = {instruction[31:12], 12'b0};

    assign pcPlus4 = pc + 32'd4;
    assign branchEqual = (rs1 == rs2);
    assign branchLess = ($signed(rs1) < $signed(rs2));

    always_comb begin
        case (pcSelect)
            PC_BRANCH: nextPc = pc + immB;
            PC_JUMP: nextPc = pc + immJ;
            // jalr clears the low target bit
            PC_JALR: nextPc = (rs1 + immI) & ~32'd1;
            default: nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        case (op1Select)
            OP1_RS1: leftOperand = rs1;
            OP1_PC: leftOperand = pc;
            default: leftOperand = 32'b0;
        endcase
        case (op2Select)
            OP2_IMM_I: rightOperand = immI;
            OP2_IMM_S: rightOperand = immS;
            OP2_IMM_U: rightOperand = immU;
            default: rightOperand = rs2;
        endcase
        case (writebackSelect)
            WB_PC4: writebackData = pcPlus4;
            WB_MEM: writebackData = memoryOut;
            default: writebackData = aluOut;
        endcase
    end

    // side effects only while executing
    assign memoryReadEnable = decodedRead && active;
    assign memoryWriteEnable = decodedWrite && active;
    assign halt = isEcall && active;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
            runDelayed <= 1'b0;
        end else begin
            runDelayed <= run;
            if (runStart) begin
                pc <= RESET_PC;
            end else if (active) begin
                pc <= nextPc;
            end
        end
    end

    RiscV1StageControl decoder (
        .instruction(instruction),
        .branchEqual(branchEqual),
        .branchLess(branchLess),
        .pcSelect(pcSelect),
        .op1Select(op1Select),
        .op2Select(op2Select),
        .aluFunction(aluFunction),
        .writebackSelect(writebackSelect),
        .regFileWriteEnable(decodedRegWrite),
        .memoryReadEnable(decodedRead),
        .memoryWriteEnable(decodedWrite),
        .isEcall(isEcall)
    );

    RegFile regFile (
        .clk(clk),
        .reset(reset),
        .readRegister1(instruction[19:15]),
        .readRegister2(instruction[24:20]),
        .writeRegister(instruction[11:7]),
        .writeData(writebackData),
        .writeEnable(decodedRegWrite && active),
        .readData1(rs1),
        .readData2(rs2),
        .readRegisterDebug(readRegisterDebug),
        .readDataDebug(readDataDebug)
    );

    RiscVAlu alu (
        .aluOp(aluFunction),
        .leftOperand(leftOperand),
        .rightOperand(rightOperand),
        .aluResult(aluOut)
    );

endmodule

// ==== verilog/RiscVAlu.sv ====
`timescale 1ns/1ns

module RiscVAlu import RiscVPkg::*; (
    input  aluOp_t      aluOp,
    input  logic [31:0] leftOperand,
    input  logic [31:0] rightOperand,
    output logic [31:0] aluResult
);
    logic [4:0] shiftAmount;

    assign shiftAmount = rightOperand[4:0];

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = leftOperand + rightOperand;
            ALU_SUB: aluResult = leftOperand - rightOperand;
            ALU_SLL: aluResult = leftOperand << shiftAmount;
            ALU_SLT: begin
                aluResult = {31'b0, $signed(leftOperand) < $signed(rightOperand)};
            end
            ALU_SLTU: begin
                aluResult = {31'b0, leftOperand < rightOperand};
            end
            ALU_XOR: aluResult = leftOperand ^ rightOperand;
            ALU_SRL: aluResult = leftOperand >> shiftAmount;
            ALU_SRA: aluResult = $unsigned($signed(leftOperand) >>> shiftAmount);
            ALU_OR: aluResult = leftOperand | rightOperand;
            ALU_AND: aluResult = leftOperand & rightOperand;
            // lui path
            ALU_COPY_B: aluResult = rightOperand;
            default: aluResult = 32'b0;
        endcase
    end

endmodule

// ==== verilog/RiscVPkg.sv ====
package RiscVPkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY_B
    } aluOp_t;

    // next pc source
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JALR} pcSel_t;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1Sel_t;

    typedef enum logic [1:0] {OP2_RS2, OP2_IMM_I, OP2_IMM_S, OP2_IMM_U} op2Sel_t;

    // register file writeback source
    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wbSel_t;

    // memory map
    localparam int MEM_WORDS = 1024;
    localparam int MEM_ADDR_BITS = 10;
    localparam logic [31:0] CTRL_ADDR = 32'h0000_4000;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // full encoding of ecall, no other SYSTEM instruction is supported
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

endpackage

// ==== verilog/RiscVSystem.sv ====
`timescale 1ns/1ns

module RiscVSystem import RiscVPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic [4:0]  readRegisterDebug,
    output logic [31:0] readDataDebug
);
    logic run;
    logic halt;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic [31:0] aluOut;
    logic [31:0] rs2;
    logic memoryReadEnable;
    logic memoryWriteEnable;
    logic [31:0] memoryOut;
    logic [MEM_ADDR_BITS-1:0] dataAddress;
    logic dataWrite;
    logic [31:0] dataWriteData;
    logic [31:0] dataReadData;

    RiscV1StageDatapath core (
        .clk(clk),
        .reset(reset),
        .run(run),
        .halt(halt),
        .pc(pc),
        .instruction(instruction),
        .aluOut(aluOut),
        .rs2(rs2),
        .memoryReadEnable(memoryReadEnable),
        .memoryWriteEnable(memoryWriteEnable),
        .memoryOut(memoryOut),
        .readRegisterDebug(readRegisterDebug),
        .readDataDebug(readDataDebug)
    );

    MemoryArbiter arbiter (
        .clk(clk),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .coreAddress(aluOut),
        .coreWriteData(rs2),
        .coreRead(memoryReadEnable),
        .coreWrite(memoryWriteEnable),
        .coreReadData(memoryOut),
        .halt(halt),
        .run(run),
        .dataAddress(dataAddress),
        .dataWrite(dataWrite),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData)
    );

    UnifiedMemory memory (
        .clk(clk),
        .fetchAddress(pc),
        .instruction(instruction),
        .dataAddress(dataAddress),
        .dataWrite(dataWrite),
        .dataWriteData(dataWriteData),
        .dataReadData(dataReadData)
    );

endmodule

// ==== verilog/UnifiedMemory.sv ====
`timescale 1ns/1ns

module UnifiedMemory import RiscVPkg::*; (
    input  logic                     clk,
    input  logic [31:0]              fetchAddress,
    output logic [31:0]              instruction,
    input  logic [MEM_ADDR_BITS-1:0] dataAddress,
    input  logic                     dataWrite,
    input  logic [31:0]              dataWriteData,
    output logic [31:0]              dataReadData
);
    logic [31:0] memory [MEM_WORDS];
    logic [MEM_ADDR_BITS-1:0] fetchIndex;

    // byte pc to word index
    assign fetchIndex = fetchAddress[MEM_ADDR_BITS+1:2];

    assign instruction = memory[fetchIndex];
    assign dataReadData = memory[dataAddress];

    always_ff @(posedge clk) begin
        if (dataWrite) begin
            memory[dataAddress] <= dataWriteData;
        end
    end

endmodule
